// ==== hdl/fan_pkg.sv ====
package fan_pkg;

	// tree geometry
	localparam int NUM_LEVELS = 5;
	localparam int NUM_PES = 1 << NUM_LEVELS;
	localparam int VN_W = $clog2(NUM_PES);
	localparam int NUM_ADDERS = NUM_PES - 1;
	localparam int CMD_W = 3;

	typedef enum logic [CMD_W-1:0] {
		CMD_IDLE       = 3'b000,
		CMD_BYPASS     = 3'b001,
		CMD_LEFT_DONE  = 3'b011,
		CMD_RIGHT_DONE = 3'b100,
		CMD_BOTH_DONE  = 3'b101
	} red_cmd_t;

	typedef logic [VN_W-1:0] vn_id_t;
	typedef logic [NUM_PES*VN_W-1:0] vn_vec_t; // leaf 0 in the low bits

	// first adder of a level in the flat add/cmd vectors
	function automatic int adder_base(int level);
		int base = 0;
		for (int j = 0; j < level; j++) begin
			base += NUM_PES >> (j + 1);
		end
		return base;
	endfunction

	function automatic int sel_side_w(int level);
		return $clog2(level);
	endfunction

	// selects exist from level 2 upwards only
	function automatic int sel_base(int level);
		int base = 0;
		for (int j = 2; j < level; j++) begin
			base += (NUM_PES >> (j + 1)) * 2 * sel_side_w(j);
		end
		return base;
	endfunction

	// leaves outside the array never match
	function automatic logic vn_match(vn_vec_t vn, int a, int b);
		if (a < 0 || a >= NUM_PES || b < 0 || b >= NUM_PES) begin
			return 1'b0;
		end
		return vn[a*VN_W +: VN_W] == vn[b*VN_W +: VN_W];
	endfunction

	localparam int SEL_W = sel_base(NUM_LEVELS); // 20 for 32 leaves

	typedef logic [NUM_ADDERS-1:0] add_vec_t;
	typedef logic [CMD_W*NUM_ADDERS-1:0] cmd_vec_t;
	typedef logic [SEL_W-1:0] sel_vec_t;

endpackage

// ==== hdl/fan_level_delay.sv ====
`timescale 1ns/100ps

module fan_level_delay #(
	parameter int DEPTH = 1,
	parameter int WIDTH = 1
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] i_d,
	output logic [WIDTH-1:0] o_q
);

	logic [DEPTH-1:0][WIDTH-1:0] stage_q; // stage 0 nearest the input

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage_q <= '0;
		end else begin
			stage_q[0] <= i_d;
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign o_q = stage_q[DEPTH-1];

endmodule

// ==== hdl/fan_leaf_ctrl.sv ====
`timescale 1ns/100ps

module fan_leaf_ctrl import fan_pkg::*; (
	input  vn_vec_t                      i_vn,
	input  logic                         i_data_valid,
	output logic [NUM_PES/2-1:0]         o_add,
	output logic [CMD_W*(NUM_PES/2)-1:0] o_cmd
);

	localparam int NA = NUM_PES / 2;

	//####################################################################
	// level 0 adders, each one sees leaves 2x and 2x+1
	//####################################################################
	for (genvar x = 0; x < NA; x++) begin : g_adder
		localparam bit INNER = (x != 0) && (x != NA - 1);
		logic pair_eq;
		logic left_done;
		logic right_done;
		red_cmd_t cmd_x;

		assign pair_eq = vn_match(i_vn, 2*x, 2*x + 1);
		assign left_done = !vn_match(i_vn, 2*x - 1, 2*x); // leaf -1 counts as different
		assign right_done = !vn_match(i_vn, 2*x + 2, 2*x + 1);

		always_comb begin
			if (!i_data_valid) begin
				cmd_x = CMD_IDLE;
			end else if (pair_eq || !(left_done || right_done)) begin
				// partial sum just passes on
				cmd_x = INNER ? CMD_BYPASS : CMD_IDLE;
			end else if (left_done && right_done) begin
				cmd_x = CMD_BOTH_DONE;
			end else if (right_done) begin
				cmd_x = CMD_RIGHT_DONE;
			end else begin
				cmd_x = CMD_LEFT_DONE;
			end
		end

		assign o_add[x] = i_data_valid && pair_eq;
		assign o_cmd[CMD_W*x +: CMD_W] = cmd_x;
	end

endmodule

// ==== hdl/fan_fwd_sel.sv ====
`timescale 1ns/100ps

module fan_fwd_sel import fan_pkg::*; #(
	parameter int LEVEL = 2,
	localparam int NA = NUM_PES >> (LEVEL + 1),
	localparam int SW = sel_side_w(LEVEL)
) (
	input  vn_vec_t              i_vn,
	input  logic                 i_data_valid,
	output logic [NA*2*SW-1:0]   o_sel
);

	localparam int H = 1 << LEVEL;

	//####################################################################
	// forwarding selects with the left field below the right field
	//####################################################################
	for (genvar x = 0; x < NA; x++) begin : g_adder
		localparam int L = 2 * H * x + H - 1;
		localparam int R = L + 1;
		logic [SW-1:0] left_sel;
		logic [SW-1:0] right_sel;

		// farthest leaf of the list wins, scanned last
		always_comb begin
			left_sel = SW'(LEVEL - 1);
			for (int k = LEVEL - 2; k >= 0; k--) begin
				if (vn_match(i_vn, L - (1 << (LEVEL - 1 - k)), L)) begin
					left_sel = SW'(k);
				end
			end
			if (!i_data_valid) begin
				left_sel = '0;
			end
		end

		always_comb begin
			right_sel = '0; // no match
			for (int j = 1; j < LEVEL; j++) begin
				if (vn_match(i_vn, R + (1 << j), R)) begin
					right_sel = SW'(j);
				end
			end
			if (!i_data_valid) begin
				right_sel = '0;
			end
		end

		assign o_sel[2*SW*x +: 2*SW] = {right_sel, left_sel};
	end

endmodule

// ==== hdl/fan_node_ctrl.sv ====
`timescale 1ns/100ps

module fan_node_ctrl import fan_pkg::*; #(
	parameter int LEVEL = 1,
	localparam int NA = NUM_PES >> (LEVEL + 1),
	localparam int SEL_LW = (LEVEL >= 2) ? NA * 2 * sel_side_w(LEVEL) : 1
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  vn_vec_t              i_vn,
	input  logic                 i_data_valid,
	output logic [NA-1:0]        o_add,
	output logic [CMD_W*NA-1:0]  o_cmd,
	output logic [SEL_LW-1:0]    o_sel
);

	localparam int H = 1 << LEVEL; // leaves under one child
	localparam int CTRL_W = NA * (1 + CMD_W);

	wire logic [NA-1:0] lvl_add;
	wire logic [CMD_W*NA-1:0] lvl_cmd;

	//####################################################################
	// add enable and done command per adder
	//####################################################################
	for (genvar x = 0; x < NA; x++) begin : g_adder
		localparam int B = 2 * H * x;
		localparam int L = B + H - 1;
		localparam int R = B + H;
		logic left_done;
		logic right_done;
		red_cmd_t cmd_x;

		// left child finished its own vn
		assign left_done = vn_match(i_vn, B + H/2 - 1, B + H/2)
			&& !vn_match(i_vn, B + H/2 - 1, B - 1)
			&& !vn_match(i_vn, B + H/2, R);
		assign right_done = vn_match(i_vn, R + H/2 - 1, R + H/2)
			&& !vn_match(i_vn, R + H/2 - 1, L)
			&& !vn_match(i_vn, R + H/2, B + 2*H);

		always_comb begin
			if (!i_data_valid) begin
				cmd_x = CMD_IDLE;
			end else if (left_done && right_done) begin
				cmd_x = CMD_BOTH_DONE;
			end else if (left_done) begin
				cmd_x = CMD_LEFT_DONE;
			end else if (right_done) begin
				cmd_x = CMD_RIGHT_DONE;
			end else begin
				cmd_x = CMD_IDLE;
			end
		end

		assign lvl_add[x] = i_data_valid && vn_match(i_vn, L, R);
		assign lvl_cmd[CMD_W*x +: CMD_W] = cmd_x;
	end

	// diagonal delay, LEVEL+1 stages
	if (LEVEL >= 2) begin : g_sel
		logic [SEL_LW-1:0] sel;
		logic [CTRL_W+SEL_LW-1:0] dly_q;

		fan_fwd_sel #(.LEVEL(LEVEL)) u_fwd_sel (
			.i_vn(i_vn),
			.i_data_valid(i_data_valid),
			.o_sel(sel)
		);
		fan_level_delay #(.DEPTH(LEVEL + 1), .WIDTH(CTRL_W + SEL_LW)) u_delay (
			.clk(clk),
			.rst_n(rst_n),
			.i_d({sel, lvl_cmd, lvl_add}),
			.o_q(dly_q)
		);
		assign {o_sel, o_cmd, o_add} = dly_q;
	end else begin : g_no_sel
		logic [CTRL_W-1:0] dly_q;

		fan_level_delay #(.DEPTH(LEVEL + 1), .WIDTH(CTRL_W)) u_delay (
			.clk(clk),
			.rst_n(rst_n),
			.i_d({lvl_cmd, lvl_add}),
			.o_q(dly_q)
		);
		assign {o_cmd, o_add} = dly_q;
		assign o_sel = '0; // no forwarding below level 2
	end

endmodule

// ==== hdl/fan_ctrl_top.sv ====
`timescale 1ns/100ps

module fan_ctrl_top import fan_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  vn_vec_t  i_vn,
	input  logic     i_data_valid,
	output add_vec_t o_reduction_add,
	output cmd_vec_t o_reduction_cmd,
	output sel_vec_t o_reduction_sel,
	output logic     o_reduction_valid
);

	localparam int LEAF_NA = NUM_PES / 2;
	localparam int LEAF_W = LEAF_NA * (1 + CMD_W) + 1; // fields plus valid

	logic [LEAF_NA-1:0] leaf_add;
	logic [CMD_W*LEAF_NA-1:0] leaf_cmd;
	logic [LEAF_W-1:0] leaf_q;
	logic valid_d;
	wire add_vec_t add_d; // aligned, before the output register
	wire cmd_vec_t cmd_d;
	wire sel_vec_t sel_d;

	//####################################################################
	// level 0 and valid, one stage ahead of the output register
	//####################################################################
	fan_leaf_ctrl u_leaf (
		.i_vn(i_vn),
		.i_data_valid(i_data_valid),
		.o_add(leaf_add),
		.o_cmd(leaf_cmd)
	);

	fan_level_delay #(.DEPTH(1), .WIDTH(LEAF_W)) u_leaf_delay (
		.clk(clk),
		.rst_n(rst_n),
		.i_d({i_data_valid, leaf_cmd, leaf_add}),
		.o_q(leaf_q)
	);
	assign {valid_d, cmd_d[0 +: CMD_W*LEAF_NA], add_d[0 +: LEAF_NA]} = leaf_q;

	//####################################################################
	// upper levels
	//####################################################################
	for (genvar l = 1; l < NUM_LEVELS; l++) begin : g_level
		localparam int NA = NUM_PES >> (l + 1);

		if (l >= 2) begin : g_fwd
			fan_node_ctrl #(.LEVEL(l)) u_node (
				.clk(clk),
				.rst_n(rst_n),
				.i_vn(i_vn),
				.i_data_valid(i_data_valid),
				.o_add(add_d[adder_base(l) +: NA]),
				.o_cmd(cmd_d[CMD_W*adder_base(l) +: CMD_W*NA]),
				.o_sel(sel_d[sel_base(l) +: NA*2*sel_side_w(l)])
			);
		end else begin : g_plain
			fan_node_ctrl #(.LEVEL(l)) u_node (
				.clk(clk),
				.rst_n(rst_n),
				.i_vn(i_vn),
				.i_data_valid(i_data_valid),
				.o_add(add_d[adder_base(l) +: NA]),
				.o_cmd(cmd_d[CMD_W*adder_base(l) +: CMD_W*NA]),
				.o_sel()
			);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_reduction_add <= '0;
			o_reduction_cmd <= '0;
			o_reduction_sel <= '0;
			o_reduction_valid <= 1'b0;
		end else begin
			o_reduction_add <= add_d;
			o_reduction_cmd <= cmd_d;
			o_reduction_sel <= sel_d;
			o_reduction_valid <= valid_d; // lines up with level 0
		end
	end

endmodule

// ==== bench/fan_ctrl_props.sv ====
`timescale 1ns/100ps

module fan_ctrl_props import fan_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     i_data_valid,
	input add_vec_t o_reduction_add,
	input cmd_vec_t o_reduction_cmd,
	input sel_vec_t o_reduction_sel,
	input logic     o_reduction_valid
);

	int prop_errors = 0;

	// async reset clears all outputs
	a_reset_clear: assert property (@(negedge clk) !rst_n |->
		o_reduction_add == '0 && o_reduction_cmd == '0
		&& o_reduction_sel == '0 && !o_reduction_valid)
		else begin
			prop_errors++;
			$error("outputs not zero while rst_n is low");
		end

	// valid lines up with level 0
	a_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
		o_reduction_valid == $past(i_data_valid, 2))
		else begin
			prop_errors++;
			$error("o_reduction_valid is not i_data_valid delayed by two edges");
		end

endmodule

bind fan_ctrl_top fan_ctrl_props i_fan_ctrl_props (.*);

// ==== bench/fan_ctrl_tb.sv ====
`timescale 1ns/100ps

module fan_ctrl_tb import fan_pkg::*; ();

	localparam int NUM_VECTORS = 80; // lfsr input sets over both streams
	localparam int TIMEOUT_NS = NUM_VECTORS * 8 + 600; // margin for reset and held sets
	localparam int HIST = 64; // ring of sampled input sets

	logic clk = 1'b0;
	logic rst_n;
	vn_vec_t i_vn;
	logic i_data_valid;
	add_vec_t o_reduction_add;
	cmd_vec_t o_reduction_cmd;
	sel_vec_t o_reduction_sel;
	logic o_reduction_valid;

	int errors = 0;
	int cyc = 0;
	logic [7:0] lfsr = 8'd60;
	vn_vec_t hist_vn [HIST];
	logic hist_v [HIST];

	always #4 clk = ~clk;

	fan_ctrl_top i_fan_ctrl_top (.*);

	function automatic logic [7:0] lfsr_step(logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]}; // taps 8 6 5 4
	endfunction

	// leaves past either end never match
	function automatic logic same_id(vn_vec_t vn, int a, int b);
		return a >= 0 && b >= 0 && a < NUM_PES && b < NUM_PES
			&& vn[a*VN_W +: VN_W] == vn[b*VN_W +: VN_W];
	endfunction

	task automatic check_val(input string name, input logic [159:0] exp, input logic [159:0] got);
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	//######################################################################
	// reference model for the controls of one input set
	//######################################################################
	task automatic ref_ctrl(input vn_vec_t vn, input logic v, output add_vec_t add,
			output cmd_vec_t cmd, output sel_vec_t sel);
		int h;
		int b;
		int a;
		int lf;
		int rt;
		int ls;
		int rs;
		int sb;
		int sw;
		logic ld;
		logic rd;
		red_cmd_t c;
		{add, cmd, sel} = '0;
		for (int l = 0; l < NUM_LEVELS && v; l++) begin
			h = 1 << l;
			sw = sel_side_w(l);
			for (int x = 0; x < (NUM_PES >> (l + 1)); x++) begin
				b = 2 * h * x;
				lf = b + h - 1;
				rt = b + h;
				a = adder_base(l) + x;
				add[a] = same_id(vn, lf, rt);
				if (l == 0) begin
					ld = !same_id(vn, b - 1, b);
					rd = !same_id(vn, b + 2, b + 1);
				end else begin
					ld = same_id(vn, b + h/2 - 1, b + h/2) && !same_id(vn, b + h/2 - 1, b - 1)
						&& !same_id(vn, b + h/2, rt);
					rd = same_id(vn, rt + h/2 - 1, rt + h/2) && !same_id(vn, rt + h/2 - 1, lf)
						&& !same_id(vn, rt + h/2, b + 2*h);
				end
				c = ld ? (rd ? CMD_BOTH_DONE : CMD_LEFT_DONE) : (rd ? CMD_RIGHT_DONE : CMD_IDLE);
				if (l == 0 && (add[a] || !(ld || rd))) begin
					c = (x == 0 || x == NUM_PES/2 - 1) ? CMD_IDLE : CMD_BYPASS;
				end
				cmd[CMD_W*a +: CMD_W] = c;
				ls = l - 1; // no match on the left
				rs = 0;
				for (int k = 0; k < l - 1; k++) begin
					if (ls == l - 1 && same_id(vn, lf - (1 << (l - 1 - k)), lf)) begin
						ls = k;
					end
					if (rs == 0 && same_id(vn, rt + (1 << (l - 1 - k)), rt)) begin
						rs = l - 1 - k;
					end
				end
				sb = sel_base(l) + 2 * sw * x;
				for (int i = 0; i < sw; i++) begin
					sel[sb + i] = ls[i];
					sel[sb + sw + i] = rs[i];
				end
			end
		end
	endtask

	always @(posedge clk) begin
		hist_vn[cyc % HIST] <= i_vn;
		hist_v[cyc % HIST] <= i_data_valid;
		cyc <= cyc + 1;
	end

	// each level shows the set sampled l+1 edges before the last one
	always @(negedge clk) begin : compare
		add_vec_t ea;
		add_vec_t ra;
		cmd_vec_t ec;
		cmd_vec_t rc;
		sel_vec_t es;
		sel_vec_t rsel;
		int idx;
		if (rst_n) begin
			for (int l = 0; l < NUM_LEVELS; l++) begin
				idx = (cyc - l - 2) % HIST;
				ref_ctrl(hist_vn[idx], hist_v[idx], ra, rc, rsel);
				for (int a = adder_base(l); a < adder_base(l + 1); a++) begin
					ea[a] = ra[a];
					ec[CMD_W*a +: CMD_W] = rc[CMD_W*a +: CMD_W];
				end
				for (int i = sel_base(l); i < sel_base(l + 1); i++) begin
					es[i] = rsel[i];
				end
			end
			check_val("o_reduction_add", ea, o_reduction_add);
			check_val("o_reduction_cmd", ec, o_reduction_cmd);
			check_val("o_reduction_sel", es, o_reduction_sel);
			check_val("o_reduction_valid", hist_v[(cyc - 2) % HIST], o_reduction_valid);
		end
	end

	task automatic drive(input vn_vec_t vn, input logic valid);
		@(posedge clk);
		i_vn <= vn;
		i_data_valid <= valid;
	endtask

	//######################################################################
	// directed tests
	//######################################################################
	task automatic check_held(input vn_vec_t vn, input add_vec_t ea, input cmd_vec_t ec,
			input sel_vec_t es);
		int n;
		repeat (NUM_LEVELS + 2) drive('0, 1'b0); // drain first
		drive(vn, 1'b1);
		n = 0;
		while (!o_reduction_valid && n < 16) begin
			@(negedge clk);
			n++;
		end
		assert (o_reduction_valid) else begin
			errors++;
			$display("o_reduction_valid never rose for a held input set");
		end
		repeat (NUM_LEVELS - 1) @(negedge clk); // top level arrives last
		check_val("o_reduction_add", ea, o_reduction_add);
		check_val("o_reduction_cmd", ec, o_reduction_cmd);
		check_val("o_reduction_sel", es, o_reduction_sel);
	endtask

	task automatic idle_after_reset();
		repeat (4) drive('0, 1'b0);
		@(negedge clk);
		check_val("all outputs", '0,
			{o_reduction_add, o_reduction_cmd, o_reduction_sel, o_reduction_valid});
	endtask

	// no match anywhere leaves every left select at l-1
	task automatic distinct_ids();
		vn_vec_t vn;
		for (int i = 0; i < NUM_PES; i++) begin
			vn[i*VN_W +: VN_W] = VN_W'(i);
		end
		check_held(vn, '0, cmd_vec_t'({(NUM_PES/2){CMD_BOTH_DONE}}),
			20'b0011_00100010_01010101);
	endtask

	// left 0 and right l-1 at levels 4 3 2
	task automatic equal_ids();
		check_held({NUM_PES{5'd9}}, '1, cmd_vec_t'({3'b000, {14{3'b001}}, 3'b000}),
			20'b1100_10001000_10101010);
	endtask

	task automatic lfsr_stream(input int n, input bit mix_valid);
		vn_vec_t vn;
		logic v;
		for (int t = 0; t < n; t++) begin
			vn = '0;
			for (int i = 1; i < NUM_PES; i++) begin
				lfsr = lfsr_step(lfsr);
				vn[i*VN_W +: VN_W] = vn[(i-1)*VN_W +: VN_W] + lfsr[0]; // same vn or next
			end
			v = 1'b1;
			if (mix_valid) begin
				lfsr = lfsr_step(lfsr);
				v = lfsr[0];
			end
			drive(vn, v);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		i_vn = '0;
		i_data_valid = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		idle_after_reset();
		distinct_ids();
		equal_ids();
		lfsr_stream(NUM_VECTORS / 2, 1'b0);
		lfsr_stream(NUM_VECTORS / 2, 1'b1);
		repeat (NUM_LEVELS + 2) drive('0, 1'b0);
		$display("check errors: %0d, property errors: %0d", errors,
			i_fan_ctrl_top.i_fan_ctrl_props.prop_errors);
		if (errors == 0 && i_fan_ctrl_top.i_fan_ctrl_props.prop_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
hdl/fan_pkg.sv
hdl/fan_level_delay.sv
hdl/fan_leaf_ctrl.sv
hdl/fan_fwd_sel.sv
hdl/fan_node_ctrl.sv
hdl/fan_ctrl_top.sv
bench/fan_ctrl_props.sv
bench/fan_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: fan_ctrl

sources:
  - target: any(rtl, test)
    files:
      - hdl/fan_pkg.sv
      - hdl/fan_level_delay.sv
      - hdl/fan_leaf_ctrl.sv
      - hdl/fan_fwd_sel.sv
      - hdl/fan_node_ctrl.sv
      - hdl/fan_ctrl_top.sv
  - target: test
    files:
      - bench/fan_ctrl_props.sv
      - bench/fan_ctrl_tb.sv
